// ==== source/mipsMemPkg.sv ====
/*
 * mipsMemPkg
 * Shared types for the memory-access stage: data widths, the load/store
 * opcodes, the decoded access kind, and the request and store trace records.
 */

`default_nettype none

package mipsMemPkg;

    // data and address words
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] instr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opLb  = 6'h20,
        opLh  = 6'h21,
        opLw  = 6'h23,
        opLbu = 6'h24,
        opLhu = 6'h25,
        opSb  = 6'h28,
        opSh  = 6'h29,
        opSw  = 6'h2B
    } opcode_t;

    // width of one access
    typedef enum logic [1:0] {
        unitWord = 2'd0,
        unitHalf = 2'd1,
        unitByte = 2'd2
    } accessUnit_t;

    // decoded access, all zero for a non-memory instruction
    typedef struct packed {
        logic        isLoad;
        logic        isStore;
        accessUnit_t unit;
        // only meaningful for half and byte loads
        logic        zeroExt;
    } accessKind_t;

    // one request per cycle, taken only when valid is high
    typedef struct packed {
        logic   valid;
        instr_t instr;
        // effective byte address
        word_t  addr;
        word_t  wdata;
        word_t  pc;
    } memRequest_t;

    // committed store, reported the cycle after the write
    typedef struct packed {
        logic  valid;
        word_t pc;
        // byte address of the written word, low two bits zero
        word_t wordAddr;
        // full word as stored after the lane merge
        word_t data;
    } storeTrace_t;

endpackage

`default_nettype wire

// ==== source/memOpDecoder.sv ====
/*
 * memOpDecoder
 * Decodes the primary opcode of an instruction word into the kind of data
 * memory access: load or store, access width and extension mode.
 */

`timescale 1ns/1ps
`default_nettype none

module memOpDecoder (
    input  wire mipsMemPkg::instr_t    instr,
    output mipsMemPkg::accessKind_t    kind
);

    mipsMemPkg::opcode_t opcode;

    // only the top six bits select a memory operation
    assign opcode = mipsMemPkg::opcode_t'(instr[31:26]);

    always_comb begin
        kind = '0;
        case (opcode)
            mipsMemPkg::opLw: begin
                kind.isLoad = 1'b1;
                kind.unit   = mipsMemPkg::unitWord;
            end
            mipsMemPkg::opLh: begin
                kind.isLoad = 1'b1;
                kind.unit   = mipsMemPkg::unitHalf;
            end
            mipsMemPkg::opLhu: begin
                kind.isLoad  = 1'b1;
                kind.unit    = mipsMemPkg::unitHalf;
                kind.zeroExt = 1'b1;
            end
            mipsMemPkg::opLb: begin
                kind.isLoad = 1'b1;
                kind.unit   = mipsMemPkg::unitByte;
            end
            mipsMemPkg::opLbu: begin
                kind.isLoad  = 1'b1;
                kind.unit    = mipsMemPkg::unitByte;
                kind.zeroExt = 1'b1;
            end
            mipsMemPkg::opSw: begin
                kind.isStore = 1'b1;
                kind.unit    = mipsMemPkg::unitWord;
            end
            mipsMemPkg::opSh: begin
                kind.isStore = 1'b1;
                kind.unit    = mipsMemPkg::unitHalf;
            end
            mipsMemPkg::opSb: begin
                kind.isStore = 1'b1;
                kind.unit    = mipsMemPkg::unitByte;
            end
            default: begin
                // not a memory instruction
                kind = '0;
            end
        endcase
    end

    // a single opcode is never both a load and a store
    always_comb begin
        assert (!(kind.isLoad && kind.isStore))
            else $error("memOpDecoder: load and store both set for %h", instr);
    end

endmodule

`default_nettype wire

// ==== source/byteLaneUnit.sv ====
/*
 * byteLaneUnit
 * Little-endian lane handling for sub-word accesses. Picks and extends the
 * addressed halfword or byte on loads, and merges store data into the
 * old word on stores.
 */

`timescale 1ns/1ps
`default_nettype none

module byteLaneUnit (
    input  wire mipsMemPkg::word_t       oldWord,
    input  wire logic [1:0]              offset,
    input  wire mipsMemPkg::accessUnit_t unit,
    input  wire logic                    zeroExt,
    input  wire mipsMemPkg::word_t       storeData,
    output mipsMemPkg::word_t            loadData,
    output mipsMemPkg::word_t            mergedWord
);

    mipsMemPkg::half_t selHalf;
    mipsMemPkg::byte_t selByte;

    // offset 0 is the least significant lane
    assign selHalf = offset[1] ? oldWord[31:16] : oldWord[15:0];
    assign selByte = oldWord[{offset, 3'b000} +: 8];

    // load path
    always_comb begin
        case (unit)
            mipsMemPkg::unitHalf: begin
                if (zeroExt) begin
                    loadData = {16'h0000, selHalf};
                end else begin
                    loadData = {{16{selHalf[15]}}, selHalf};
                end
            end
            mipsMemPkg::unitByte: begin
                if (zeroExt) begin
                    loadData = {24'h00_0000, selByte};
                end else begin
                    loadData = {{24{selByte[7]}}, selByte};
                end
            end
            default: begin
                loadData = oldWord;
            end
        endcase
    end

    // store path, untouched lanes keep the old contents
    always_comb begin
        mergedWord = oldWord;
        case (unit)
            mipsMemPkg::unitHalf: begin
                if (offset[1]) begin
                    mergedWord[31:16] = storeData[15:0];
                end else begin
                    mergedWord[15:0] = storeData[15:0];
                end
            end
            mipsMemPkg::unitByte: begin
                mergedWord[{offset, 3'b000} +: 8] = storeData[7:0];
            end
            default: begin
                mergedWord = storeData;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/dataMemory.sv ====
/*
 * dataMemory
 * Word-organised data memory with range and alignment checking.
 * Loads return combinationally, stores commit at the clock edge and are
 * reported on the trace port one cycle later. Reset clears every word.
 */

`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
    parameter mipsMemPkg::word_t dataStartAddr = 32'h0000_3000,
    parameter int                memWords      = 1024
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire mipsMemPkg::memRequest_t request,
    input  wire mipsMemPkg::accessKind_t kind,
    output mipsMemPkg::word_t            rdata,
    output logic                         fault,
    output mipsMemPkg::storeTrace_t      trace
);

    localparam int indexBits = $clog2(memWords);
    localparam mipsMemPkg::word_t memBytes = mipsMemPkg::word_t'(4 * memWords);

    // size must be a power of two so the index covers the array exactly
    if ((memWords < 2) || ((memWords & (memWords - 1)) != 0)) begin : gSizeCheck
        $error("dataMemory: memWords (%0d) is not a power of two", memWords);
    end

    mipsMemPkg::word_t mem [memWords];

    mipsMemPkg::word_t     offsetAddr;
    logic [indexBits-1:0]  wordIndex;
    logic                  isAccess;
    logic                  inRange;
    logic                  aligned;
    logic                  writeEn;
    mipsMemPkg::word_t     oldWord;
    mipsMemPkg::word_t     loadData;
    mipsMemPkg::word_t     mergedWord;

    // address relative to the start of data memory
    assign offsetAddr = request.addr - dataStartAddr;
    assign wordIndex  = offsetAddr[indexBits+1:2];

    // comparing the offset avoids overflow of base plus size
    assign inRange = (request.addr >= dataStartAddr) && (offsetAddr < memBytes);

    always_comb begin
        case (kind.unit)
            mipsMemPkg::unitWord: aligned = (request.addr[1:0] == 2'b00);
            mipsMemPkg::unitHalf: aligned = (request.addr[0] == 1'b0);
            default:              aligned = 1'b1;
        endcase
    end

    assign isAccess = request.valid && (kind.isLoad || kind.isStore);
    assign fault    = isAccess && !(inRange && aligned);
    assign writeEn  = request.valid && kind.isStore && !fault;

    // index stays inside the array even when the address is out of range
    assign oldWord = mem[wordIndex];

    byteLaneUnit lanes_i (
        .oldWord   (oldWord),
        .offset    (request.addr[1:0]),
        .unit      (kind.unit),
        .zeroExt   (kind.zeroExt),
        .storeData (request.wdata),
        .loadData  (loadData),
        .mergedWord(mergedWord)
    );

    assign rdata = (request.valid && kind.isLoad && !fault) ? loadData : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEn) begin
            mem[wordIndex] <= mergedWord;
        end
    end

    // store trace, payload only loads on a commit
    always_ff @(posedge clk) begin
        if (reset) begin
            trace.valid <= 1'b0;
        end else begin
            trace.valid <= writeEn;
        end
        if (writeEn) begin
            trace.pc       <= request.pc;
            trace.wordAddr <= {request.addr[31:2], 2'b00};
            trace.data     <= mergedWord;
        end
    end

    // a trace always follows a valid store opcode from the decoder
    assert property (@(posedge clk) disable iff (reset)
        trace.valid |-> $past(request.valid && kind.isStore))
        else $error("dataMemory: trace without a preceding store");

    // the word index must address the same word as the request
    assert property (@(posedge clk) disable iff (reset)
        writeEn |-> (dataStartAddr + {wordIndex, 2'b00}) == {request.addr[31:2], 2'b00})
        else $error("dataMemory: write index outside the memory range");

endmodule

`default_nettype wire

// ==== source/memStage.sv ====
/*
 * memStage
 * Memory-access stage top level. Decodes the load/store opcode and
 * drives the data memory, which returns load data, faults and store trace.
 */

`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter mipsMemPkg::word_t dataStartAddr = 32'h0000_3000,
    parameter int                memWords      = 1024
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire mipsMemPkg::memRequest_t request,
    output mipsMemPkg::word_t            rdata,
    output logic                         fault,
    output mipsMemPkg::storeTrace_t      trace
);

    mipsMemPkg::accessKind_t kind;

    memOpDecoder decoder_i (
        .instr(request.instr),
        .kind (kind)
    );

    // memory geometry comes from this level
    dataMemory #(
        .dataStartAddr(dataStartAddr),
        .memWords     (memWords)
    ) memory_i (
        .clk    (clk),
        .reset  (reset),
        .request(request),
        .kind   (kind),
        .rdata  (rdata),
        .fault  (fault),
        .trace  (trace)
    );

endmodule

`default_nettype wire

// ==== sim/memStageVectors.svh ====
/*
 * memStageVectors
 * Directed stimulus for the memory stage testbench with opcode constants and
 * a table of rows holding test number, opcode, byte address and store data.
 */

// primary opcodes in instr[31:26]
localparam logic [5:0] opLb  = 6'h20;
localparam logic [5:0] opLh  = 6'h21;
localparam logic [5:0] opLw  = 6'h23;
localparam logic [5:0] opLbu = 6'h24;
localparam logic [5:0] opLhu = 6'h25;
localparam logic [5:0] opSb  = 6'h28;
localparam logic [5:0] opSh  = 6'h29;
localparam logic [5:0] opSw  = 6'h2B;

typedef struct packed {
    logic [3:0]  testId;
    logic [5:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
} vector_t;

localparam int numVectors = 44;

vector_t vectors [numVectors] = '{
    // test 1 reads words across the range after reset
    '{4'd1, opLw,  32'h0000_3000, 32'h0000_0000},
    '{4'd1, opLw,  32'h0000_3004, 32'h0000_0000},
    '{4'd1, opLw,  32'h0000_3800, 32'h0000_0000},
    '{4'd1, opLw,  32'h0000_3FFC, 32'h0000_0000},
    // test 2 covers round trips and lane merges
    '{4'd2, opSw,  32'h0000_3010, 32'h1234_5678},
    '{4'd2, opLw,  32'h0000_3010, 32'h0000_0000},
    '{4'd2, opSh,  32'h0000_3012, 32'h0000_BEEF},
    '{4'd2, opLw,  32'h0000_3010, 32'h0000_0000},
    '{4'd2, opSb,  32'h0000_3011, 32'h0000_00A5},
    '{4'd2, opLw,  32'h0000_3010, 32'h0000_0000},
    // back-to-back byte stores into one word
    '{4'd2, opSb,  32'h0000_3014, 32'hFFFF_FF11},
    '{4'd2, opSb,  32'h0000_3015, 32'hFFFF_FF22},
    '{4'd2, opLw,  32'h0000_3014, 32'h0000_0000},
    // test 3 sets the top bit of every byte and halfword
    '{4'd3, opSw,  32'h0000_3020, 32'h9ABC_F0E1},
    '{4'd3, opLb,  32'h0000_3020, 32'h0000_0000},
    '{4'd3, opLb,  32'h0000_3021, 32'h0000_0000},
    '{4'd3, opLb,  32'h0000_3022, 32'h0000_0000},
    '{4'd3, opLb,  32'h0000_3023, 32'h0000_0000},
    '{4'd3, opLbu, 32'h0000_3020, 32'h0000_0000},
    '{4'd3, opLbu, 32'h0000_3021, 32'h0000_0000},
    '{4'd3, opLbu, 32'h0000_3022, 32'h0000_0000},
    '{4'd3, opLbu, 32'h0000_3023, 32'h0000_0000},
    '{4'd3, opLh,  32'h0000_3020, 32'h0000_0000},
    '{4'd3, opLh,  32'h0000_3022, 32'h0000_0000},
    '{4'd3, opLhu, 32'h0000_3020, 32'h0000_0000},
    '{4'd3, opLhu, 32'h0000_3022, 32'h0000_0000},
    // test 4 tries below, above and misaligned accesses
    '{4'd4, opLw,  32'h0000_2FFC, 32'h0000_0000},
    '{4'd4, opLw,  32'h0000_4000, 32'h0000_0000},
    '{4'd4, opLw,  32'h0000_3002, 32'h0000_0000},
    '{4'd4, opLh,  32'h0000_3021, 32'h0000_0000},
    '{4'd4, opLb,  32'h0000_4000, 32'h0000_0000},
    '{4'd4, opSw,  32'h0000_4000, 32'hFFFF_FFFF},
    '{4'd4, opSw,  32'h0000_2FFC, 32'hFFFF_FFFF},
    '{4'd4, opSh,  32'h0000_3011, 32'h0000_FFFF},
    '{4'd4, opSw,  32'h0000_3012, 32'hFFFF_FFFF},
    '{4'd4, opLw,  32'h0000_3010, 32'h0000_0000},
    // words that the out-of-range stores would alias
    '{4'd4, opLw,  32'h0000_3000, 32'h0000_0000},
    '{4'd4, opLw,  32'h0000_3FFC, 32'h0000_0000},
    // test 5 uses opcodes outside the load/store set
    '{4'd5, 6'h00, 32'h0000_3010, 32'hFFFF_FFFF},
    '{4'd5, 6'h0F, 32'h0000_3010, 32'hFFFF_FFFF},
    '{4'd5, 6'h22, 32'h0000_3010, 32'hFFFF_FFFF},
    '{4'd5, 6'h2A, 32'h0000_3010, 32'hFFFF_FFFF},
    '{4'd5, 6'h3F, 32'h0000_3010, 32'hFFFF_FFFF},
    '{4'd5, opLw,  32'h0000_3010, 32'h0000_0000}
};

// ==== sim/tbMemStage.sv ====
/*
 * tbMemStage
 * Testbench for the memory-access stage. Runs a directed table and a random
 * mixed sequence against a shadow memory and checks load data, fault and
 * the store trace in every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module tbMemStage;

    localparam logic [31:0] memBase     = 32'h0000_3000;
    localparam int          memWords    = 1024;
    localparam int          randomCount = 300;
    localparam int          clkPeriod   = 8;

    `include "memStageVectors.svh"

    logic                    clk;
    logic                    reset;
    mipsMemPkg::memRequest_t request;
    mipsMemPkg::word_t       rdata;
    logic                    fault;
    mipsMemPkg::storeTrace_t trace;

    logic [31:0]             shadow [memWords];
    mipsMemPkg::storeTrace_t expTrace;
    logic [31:0]             pcCounter;
    logic [31:0]             rngState;
    int                      checkCount;
    int                      errorCount;
    int                      testErrors;
    int                      testsRun;
    int                      testsPassed;
    string testNames [7] = '{"", "reset clear", "store and load round trip",
        "load extension", "fault handling", "non-memory opcodes", "random mix"};

    memStage dut_i (
        .clk    (clk),
        .reset  (reset),
        .request(request),
        .rdata  (rdata),
        .fault  (fault),
        .trace  (trace)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // whole run bounded at four times its expected length
    initial begin
        #((numVectors + randomCount + 50) * clkPeriod * 4);
        $display("timeout: the run did not reach its end in time");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // bytes moved by an opcode or 0 for no access
    function automatic int accessSize(input logic [5:0] op);
        case (op)
            opLw, opSw:        return 4;
            opLh, opLhu, opSh: return 2;
            opLb, opLbu, opSb: return 1;
            default:           return 0;
        endcase
    endfunction

    function automatic logic isStoreOp(input logic [5:0] op);
        return (op == opSw) || (op == opSh) || (op == opSb);
    endfunction

    // addressed lane shifted down and then extended
    function automatic logic [31:0] expectedLoad(input logic [5:0] op,
                                                 input logic [31:0] word,
                                                 input logic [1:0] offset);
        logic [31:0] shifted;
        shifted = word >> (8 * offset);
        case (op)
            opLb:    return {{24{shifted[7]}}, shifted[7:0]};
            opLbu:   return {24'h0, shifted[7:0]};
            opLh:    return {{16{shifted[15]}}, shifted[15:0]};
            opLhu:   return {16'h0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] mergeStore(input logic [5:0] op,
                                               input logic [31:0] oldWord,
                                               input logic [31:0] data,
                                               input logic [1:0] offset);
        logic [31:0] laneMask;
        laneMask = (32'hFFFF_FFFF >> (32 - 8 * accessSize(op))) << (8 * offset);
        return (oldWord & ~laneMask) | ((data << (8 * offset)) & laneMask);
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("MISMATCH time %0t %s actual %h expected %h",
                     $time, name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkTrace();
        checkCount++;
        if (expTrace.valid && (trace.valid !== 1'b1)) begin
            $display("time %0t: store trace missing for the store at pc %h",
                     $time, expTrace.pc);
            errorCount++;
            testErrors++;
        end else if (!expTrace.valid && (trace.valid !== 1'b0)) begin
            $display("time %0t: trace appeared without a committed store", $time);
            errorCount++;
            testErrors++;
        end else if (expTrace.valid) begin
            compareValue("trace.pc", trace.pc, expTrace.pc);
            compareValue("trace.wordAddr", trace.wordAddr, expTrace.wordAddr);
            compareValue("trace.data", trace.data, expTrace.data);
        end
    endtask

    // compares the outputs for the applied request and updates the model
    task automatic checkCycle();
        logic [5:0]  op;
        logic [31:0] addr;
        logic [31:0] oldWord;
        logic [31:0] expRdata;
        logic [31:0] newWord;
        logic        access;
        logic        inRange;
        logic        aligned;
        logic        expFault;
        int          size;
        int          index;
        op       = request.instr[31:26];
        addr     = request.addr;
        size     = accessSize(op);
        access   = request.valid && (size != 0);
        inRange  = (addr >= memBase) && (addr < memBase + 4 * memWords);
        aligned  = 1'b1;
        if (size != 0) begin
            aligned = ((addr % size) == 0);
        end
        expFault = access && !(inRange && aligned);
        index    = inRange ? int'((addr - memBase) >> 2) : 0;
        oldWord  = shadow[index];
        expRdata = '0;
        if (access && !isStoreOp(op) && !expFault) begin
            expRdata = expectedLoad(op, oldWord, addr[1:0]);
        end
        compareValue("rdata", rdata, expRdata);
        compareValue("fault", fault, expFault);
        checkTrace();
        if (access && isStoreOp(op) && !expFault) begin
            newWord       = mergeStore(op, oldWord, request.wdata, addr[1:0]);
            shadow[index] = newWord;
            expTrace      = {1'b1, request.pc, addr[31:2], 2'b00, newWord};
        end else begin
            expTrace.valid = 1'b0;
        end
    endtask

    task automatic applyRequest(input logic valid, input logic [5:0] op,
                                input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [25:0] lowBits);
        @(posedge clk);
        request.valid <= valid;
        request.instr <= {op, lowBits};
        request.addr  <= addr;
        request.wdata <= wdata;
        request.pc    <= pcCounter;
        pcCounter = pcCounter + 32'd4;
        @(negedge clk);
        checkCycle();
    endtask

    task automatic finishTest(input int id);
        testsRun++;
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %0d (%s) ok", id, testNames[id]);
        end else begin
            $display("test %0d (%s) failed with %0d errors", id, testNames[id], testErrors);
        end
        testErrors = 0;
    endtask

    task automatic runRandom();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] lowBits;
        logic [5:0]  op;
        logic [1:0]  offset;
        logic        valid;
        logic [5:0]  memOps [8] = '{opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
        for (int n = 0; n < randomCount; n++) begin
            r = nextRandom();
            op = (r[3:0] == 4'd0) ? r[31:26] : memOps[r[6:4]];
            // one request in eight keeps its raw offset
            offset = r[12:11];
            if (r[15:13] != 3'd0) begin
                if (accessSize(op) == 4) begin
                    offset = 2'd0;
                end else if (accessSize(op) == 2) begin
                    offset[0] = 1'b0;
                end
            end
            // only eight words so that stores and loads often meet
            addr = memBase + 32'h100 + {27'b0, r[10:8], 2'b00} + {30'b0, offset};
            if (r[20:16] == 5'd0) begin
                addr = r[21] ? memBase - 32'd8 + offset : memBase + 4 * memWords + offset;
            end
            valid   = (r[25:22] != 4'd0);
            wdata   = nextRandom();
            lowBits = nextRandom();
            applyRequest(valid, op, addr, wdata, lowBits[25:0]);
        end
        // idle cycle so the trace of the last request is checked
        applyRequest(1'b0, 6'h00, memBase, 32'h0, 26'h0);
    endtask

    initial begin
        int currentTest;
        checkCount  = 0;
        errorCount  = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsPassed = 0;
        pcCounter   = 32'h0040_0000;
        rngState    = 32'd31644;
        expTrace    = '0;
        for (int i = 0; i < memWords; i++) begin
            shadow[i] = '0;
        end
        // a store held during reset must not land
        reset         = 1'b1;
        request.valid = 1'b1;
        request.instr = {opSw, 26'h0};
        request.addr  = memBase;
        request.wdata = 32'hDEAD_BEEF;
        request.pc    = 32'h0;
        repeat (10) @(posedge clk);
        reset         <= 1'b0;
        request.valid <= 1'b0;
        @(negedge clk);
        checkCycle();

        currentTest = vectors[0].testId;
        for (int i = 0; i < numVectors; i++) begin
            if (vectors[i].testId != currentTest) begin
                finishTest(currentTest);
                currentTest = vectors[i].testId;
            end
            applyRequest(1'b1, vectors[i].op, vectors[i].addr, vectors[i].wdata, 26'h0A5_0010);
        end
        finishTest(currentTest);
        runRandom();
        finishTest(6);

        $display("tests passed %0d of %0d, checks %0d, errors %0d",
                 testsPassed, testsRun, checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+sim
source/mipsMemPkg.sv
source/memOpDecoder.sv
source/byteLaneUnit.sv
source/dataMemory.sv
source/memStage.sv
sim/tbMemStage.sv

// ==== Bender.yml ====
package:
  name: mips_mem_stage

sources:
  - files:
      - source/mipsMemPkg.sv
      - source/memOpDecoder.sv
      - source/byteLaneUnit.sv
      - source/dataMemory.sv
      - source/memStage.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tbMemStage.sv
